//--- arm_pkg.sv
package arm_pkg;

    // memory sizes
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // datapath words
    typedef logic [31:0] word_t;
    // byte address into instruction memory
    typedef logic [7:0] pc_t;
    typedef logic [3:0] reg_idx_t;
    // n z c v, n on top
    typedef logic [3:0] flags_t;

    // sequential fetch increment
    localparam pc_t PC_STEP = 8'd4;

    // opcode field, bits 24..21
    typedef enum logic [3:0] {
        op_and = 4'b0000,
        op_eor = 4'b0001,
        op_sub = 4'b0010,
        op_add = 4'b0100,
        op_orr = 4'b1100,
        op_mov = 4'b1101
    } alu_op_e;

    // condition field, bits 31..28
    typedef enum logic [3:0] {
        cond_eq, cond_ne, cond_cs, cond_cc,
        cond_mi, cond_pl, cond_vs, cond_vc,
        cond_hi, cond_ls, cond_ge, cond_lt,
        cond_gt, cond_le, cond_al, cond_nv
    } cond_e;

    // class field, bits 27..25
    typedef enum logic [2:0] {
        cls_dp_reg   = 3'b000,
        cls_dp_imm   = 3'b001,
        cls_ldst_imm = 3'b010,
        cls_branch   = 3'b101
    } instr_class_e;

    // decode operand source
    typedef enum logic [1:0] {
        fwd_rf  = 2'b00,
        fwd_ex  = 2'b01,
        fwd_mem = 2'b10,
        fwd_wb  = 2'b11
    } fwd_sel_e;

endpackage

//--- pipe_ifs.sv
// decoded instruction, ID/EX register contents
interface exec_bus_if;
    import arm_pkg::*;

    logic valid;
    word_t op_a;
    word_t op_b;
    word_t store_data;
    reg_idx_t dest;
    alu_op_e alu_op;
    logic set_flags;
    logic is_load;
    logic is_store;
    logic reg_write;

    modport decode (output valid, op_a, op_b, store_data, dest, alu_op,
                    set_flags, is_load, is_store, reg_write);
    modport execute (input valid, op_a, op_b, store_data, dest, alu_op,
                     set_flags, is_load, is_store, reg_write);
endinterface

// per-stage writer info for forwarding and load-use detection
interface stage_status_if;
    import arm_pkg::*;

    // write flags already include the stage valid
    logic ex_write, ex_load, mem_write, wb_write;
    reg_idx_t ex_dest, mem_dest, wb_dest;
    word_t ex_result, mem_result, wb_data;

    modport ex_side (output ex_dest, ex_write, ex_load, ex_result);
    modport mem_side (output mem_dest, mem_write, mem_result);
    modport wb_side (output wb_dest, wb_write, wb_data);
    modport hazard (input ex_dest, ex_write, ex_load, mem_dest, mem_write,
                    wb_dest, wb_write);
    modport forward (input ex_result, mem_result, wb_data);
endinterface

//--- fetch_stage.sv
module fetch_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         branch_taken,
    input  arm_pkg::pc_t                 branch_target,
    input  logic                         imem_we,
    input  logic [arm_pkg::IMEM_AW-1:0]  imem_addr,
    input  arm_pkg::word_t               imem_wdata,
    output logic                         if_valid,
    output arm_pkg::word_t               if_instr,
    output arm_pkg::pc_t                 if_pc_next
);
    import arm_pkg::*;

    word_t imem [IMEM_WORDS];
    pc_t pc;
    pc_t pc_plus;
    word_t fetched;

    // word aligned fetch, low two pc bits ignored
    assign pc_plus = pc + PC_STEP;
    assign fetched = imem[pc[IMEM_AW+1:2]];

    // program load port, used by the testbench under reset
    always_ff @(posedge clk)
    begin
        if (imem_we)
            imem[imem_addr] <= imem_wdata;
    end

    // taken branch wins, stall freezes the pc
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= '0;
        else if (branch_taken)
            pc <= branch_target;
        else if (!stall)
            pc <= pc_plus;
    end

    // IF/ID valid, cleared by a flush
    always_ff @(posedge clk)
    begin
        if (rst || branch_taken)
            if_valid <= 1'b0;
        else if (!stall)
            if_valid <= 1'b1;
    end

    // IF/ID payload
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            if_instr <= fetched;
            if_pc_next <= pc_plus;
        end
    end

endmodule

//--- reg_file.sv
module reg_file (
    input  logic               clk,
    input  arm_pkg::reg_idx_t  ra,
    input  arm_pkg::reg_idx_t  rb,
    input  arm_pkg::reg_idx_t  rd_sel,
    input  logic               we,
    input  arm_pkg::reg_idx_t  wa,
    input  arm_pkg::word_t     wd,
    output arm_pkg::word_t     a_data,
    output arm_pkg::word_t     b_data,
    output arm_pkg::word_t     d_data
);
    import arm_pkg::*;

    word_t regs [16];

    // async reads; rn, rm and store data
    assign a_data = regs[ra];
    assign b_data = regs[rb];
    assign d_data = regs[rd_sel];

    // write back from MEM/WB
    always_ff @(posedge clk)
    begin
        if (we)
            regs[wa] <= wd;
    end

endmodule

//--- decode_stage.sv
module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                if_valid,
    input  arm_pkg::word_t      if_instr,
    input  arm_pkg::pc_t        if_pc_next,
    input  arm_pkg::fwd_sel_e   sel_a,
    input  arm_pkg::fwd_sel_e   sel_b,
    input  arm_pkg::fwd_sel_e   sel_d,
    input  logic                stall,
    output logic                branch_taken,
    output arm_pkg::pc_t        branch_target,
    output arm_pkg::reg_idx_t   ra,
    output arm_pkg::reg_idx_t   rb,
    output arm_pkg::reg_idx_t   rd_sel,
    output logic                uses_b,
    output logic                uses_d,
    input  arm_pkg::word_t      a_data,
    input  arm_pkg::word_t      b_data,
    input  arm_pkg::word_t      d_data,
    input  arm_pkg::flags_t     flags,
    stage_status_if.forward     fwd,
    exec_bus_if.decode          ex
);
    import arm_pkg::*;

    instr_class_e cls;
    cond_e cond;
    logic is_dp, is_ldst, is_branch;
    logic load_bit, up_bit, s_bit;
    word_t a_val, b_val, d_val, op_b;
    word_t br_offset;
    alu_op_e alu_op;
    logic id_live;

    // nzcv test, flags are n z c v from msb
    function automatic logic cond_pass(input cond_e c, input flags_t f);
        logic n, z, cf, v;
        n = f[3];
        z = f[2];
        cf = f[1];
        v = f[0];
        case (c)
            cond_eq: return z;
            cond_ne: return !z;
            cond_cs: return cf;
            cond_cc: return !cf;
            cond_mi: return n;
            cond_pl: return !n;
            cond_vs: return v;
            cond_vc: return !v;
            cond_hi: return cf && !z;
            cond_ls: return !cf || z;
            cond_ge: return n == v;
            cond_lt: return n != v;
            cond_gt: return !z && (n == v);
            cond_le: return z || (n != v);
            cond_al: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // one forwarding mux, used for all three operands
    function automatic word_t pick(input fwd_sel_e sel, input word_t rf_val,
                                   input word_t ex_v, input word_t mem_v, input word_t wb_v);
        case (sel)
            fwd_ex:  return ex_v;
            fwd_mem: return mem_v;
            fwd_wb:  return wb_v;
            default: return rf_val;
        endcase
    endfunction

    assign cls = instr_class_e'(if_instr[27:25]);
    assign cond = cond_e'(if_instr[31:28]);
    assign is_dp = (cls == cls_dp_reg) || (cls == cls_dp_imm);
    assign is_ldst = (cls == cls_ldst_imm);
    assign is_branch = (cls == cls_branch);
    assign s_bit = if_instr[20];
    assign load_bit = if_instr[20];
    assign up_bit = if_instr[23];

    // register fields: rn, rm, rd (store data)
    assign ra = if_instr[19:16];
    assign rb = if_instr[3:0];
    assign rd_sel = if_instr[15:12];
    assign uses_b = (cls == cls_dp_reg);
    assign uses_d = is_ldst && !load_bit;

    assign a_val = pick(sel_a, a_data, fwd.ex_result, fwd.mem_result, fwd.wb_data);
    assign b_val = pick(sel_b, b_data, fwd.ex_result, fwd.mem_result, fwd.wb_data);
    assign d_val = pick(sel_d, d_data, fwd.ex_result, fwd.mem_result, fwd.wb_data);

    // imm8 for dp immediate, imm12 for load/store offset
    always_comb
    begin
        if (cls == cls_dp_imm)
            op_b = {24'b0, if_instr[7:0]};
        else if (is_ldst)
            op_b = {20'b0, if_instr[11:0]};
        else
            op_b = b_val;
    end

    // address calc uses the U bit for direction
    assign alu_op = is_ldst ? (up_bit ? op_add : op_sub) : alu_op_e'(if_instr[24:21]);

    // target = pc + 4 + sext(imm24) * 4, wraps in 8 bits
    assign br_offset = {{6{if_instr[23]}}, if_instr[23:0], 2'b00};
    assign branch_target = if_pc_next + br_offset[7:0];
    // a stalled branch is re-evaluated next cycle
    assign branch_taken = if_valid && !stall && is_branch && cond_pass(cond, flags);

    assign id_live = if_valid && !stall;

    // ID/EX register, bubble under stall
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex.valid <= 1'b0;
            ex.set_flags <= 1'b0;
            ex.is_load <= 1'b0;
            ex.is_store <= 1'b0;
            ex.reg_write <= 1'b0;
        end
        else
        begin
            ex.valid <= id_live;
            ex.set_flags <= id_live && is_dp && s_bit;
            ex.is_load <= id_live && is_ldst && load_bit;
            ex.is_store <= id_live && is_ldst && !load_bit;
            // branches and stores write nothing
            ex.reg_write <= id_live && (is_dp || (is_ldst && load_bit));
        end
        ex.op_a <= a_val;
        ex.op_b <= op_b;
        ex.store_data <= d_val;
        ex.dest <= rd_sel;
        ex.alu_op <= alu_op;
    end

endmodule

//--- hazard_unit.sv
module hazard_unit (
    input  arm_pkg::reg_idx_t  ra,
    input  arm_pkg::reg_idx_t  rb,
    input  arm_pkg::reg_idx_t  rd_sel,
    input  logic               uses_b,
    input  logic               uses_d,
    stage_status_if.hazard     st,
    output arm_pkg::fwd_sel_e  sel_a,
    output arm_pkg::fwd_sel_e  sel_b,
    output arm_pkg::fwd_sel_e  sel_d,
    output logic               stall
);
    import arm_pkg::*;

    logic ex_hit_a, ex_hit_b, ex_hit_d;

    // youngest writer first: EX, then MEM, then WB
    function automatic fwd_sel_e src_for(input reg_idx_t r,
                                         input logic ex_w, input reg_idx_t ex_d,
                                         input logic mem_w, input reg_idx_t mem_d,
                                         input logic wb_w, input reg_idx_t wb_d);
        if (ex_w && ex_d == r)
            return fwd_ex;
        else if (mem_w && mem_d == r)
            return fwd_mem;
        else if (wb_w && wb_d == r)
            return fwd_wb;
        return fwd_rf;
    endfunction

    assign sel_a = src_for(ra, st.ex_write, st.ex_dest, st.mem_write, st.mem_dest,
                           st.wb_write, st.wb_dest);
    assign sel_b = src_for(rb, st.ex_write, st.ex_dest, st.mem_write, st.mem_dest,
                           st.wb_write, st.wb_dest);
    assign sel_d = src_for(rd_sel, st.ex_write, st.ex_dest, st.mem_write, st.mem_dest,
                           st.wb_write, st.wb_dest);

    // rn treated as always read, conservative for mov and branch
    assign ex_hit_a = st.ex_dest == ra;
    assign ex_hit_b = uses_b && (st.ex_dest == rb);
    assign ex_hit_d = uses_d && (st.ex_dest == rd_sel);

    // load data only exists after MEM, so wait one cycle
    assign stall = st.ex_load && st.ex_write && (ex_hit_a || ex_hit_b || ex_hit_d);

endmodule

//--- execute_stage.sv
module execute_stage (
    input  logic               clk,
    input  logic               rst,
    exec_bus_if.execute        ex,
    stage_status_if.ex_side    st,
    output arm_pkg::flags_t    flags,
    output arm_pkg::word_t     mem_addr,
    output arm_pkg::word_t     mem_wdata,
    output logic               mem_load,
    output logic               mem_store,
    output arm_pkg::reg_idx_t  mem_dest,
    output logic               mem_write,
    output logic               mem_valid
);
    import arm_pkg::*;

    word_t result;
    flags_t alu_flags;
    logic [32:0] sum;

    // alu; logic ops keep c and v
    always_comb
    begin
        sum = '0;
        alu_flags = flags;
        case (ex.alu_op)
            op_and: result = ex.op_a & ex.op_b;
            op_eor: result = ex.op_a ^ ex.op_b;
            op_orr: result = ex.op_a | ex.op_b;
            op_add:
            begin
                sum = {1'b0, ex.op_a} + {1'b0, ex.op_b};
                result = sum[31:0];
                alu_flags[1] = sum[32];
                alu_flags[0] = (ex.op_a[31] == ex.op_b[31]) && (result[31] != ex.op_a[31]);
            end
            op_sub:
            begin
                // carry out of a + ~b + 1 is not-borrow
                sum = {1'b0, ex.op_a} + {1'b0, ~ex.op_b} + 33'd1;
                result = sum[31:0];
                alu_flags[1] = sum[32];
                alu_flags[0] = (ex.op_a[31] != ex.op_b[31]) && (result[31] != ex.op_a[31]);
            end
            default: result = ex.op_b;
        endcase
        alu_flags[3] = result[31];
        alu_flags[2] = (result == '0);
    end

    // status register
    always_ff @(posedge clk)
    begin
        if (rst)
            flags <= '0;
        else if (ex.valid && ex.set_flags)
            flags <= alu_flags;
    end

    // EX view for the hazard unit and decode forwarding
    assign st.ex_dest = ex.dest;
    assign st.ex_write = ex.valid && ex.reg_write;
    assign st.ex_load = ex.valid && ex.is_load;
    assign st.ex_result = result;

    // EX/MEM register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_valid <= 1'b0;
            mem_load <= 1'b0;
            mem_store <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            mem_valid <= ex.valid;
            mem_load <= ex.valid && ex.is_load;
            mem_store <= ex.valid && ex.is_store;
            mem_write <= ex.valid && ex.reg_write;
        end
        mem_addr <= result;
        mem_wdata <= ex.store_data;
        mem_dest <= ex.dest;
    end

endmodule

//--- memory_stage.sv
module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  arm_pkg::word_t     mem_addr,
    input  arm_pkg::word_t     mem_wdata,
    input  logic               mem_load,
    input  logic               mem_store,
    input  arm_pkg::reg_idx_t  mem_dest,
    input  logic               mem_write,
    input  logic               mem_valid,
    stage_status_if.mem_side   mst,
    stage_status_if.wb_side    wst,
    output logic               wb_valid,
    output arm_pkg::reg_idx_t  wb_reg,
    output arm_pkg::word_t     wb_data,
    output logic               wb_we
);
    import arm_pkg::*;

    word_t dmem [DMEM_WORDS];
    word_t rdata;
    word_t result;

    // word addressed, bits 7..2
    assign rdata = dmem[mem_addr[DMEM_AW+1:2]];

    always_ff @(posedge clk)
    begin
        if (mem_valid && mem_store)
            dmem[mem_addr[DMEM_AW+1:2]] <= mem_wdata;
    end

    // loaded word replaces the address
    assign result = mem_load ? rdata : mem_addr;

    assign mst.mem_dest = mem_dest;
    assign mst.mem_write = mem_write;
    assign mst.mem_result = result;

    // MEM/WB register, only register writers retire
    always_ff @(posedge clk)
    begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_valid && mem_write;
        wb_reg <= mem_dest;
        wb_data <= result;
    end

    assign wb_we = wb_valid;
    assign wst.wb_dest = wb_reg;
    assign wst.wb_write = wb_valid;
    assign wst.wb_data = wb_data;

endmodule

//--- arm_pipeline.sv
module arm_pipeline (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         imem_we,
    input  logic [arm_pkg::IMEM_AW-1:0]  imem_addr,
    input  arm_pkg::word_t               imem_wdata,
    output logic                         wb_valid,
    output arm_pkg::reg_idx_t            wb_reg,
    output arm_pkg::word_t               wb_data
);
    import arm_pkg::*;

    // fetch to decode
    logic if_valid, branch_taken;
    word_t if_instr;
    pc_t if_pc_next, branch_target;
    // decode, register file and hazard unit
    reg_idx_t ra, rb, rd_sel;
    logic uses_b, uses_d, stall;
    word_t a_data, b_data, d_data;
    fwd_sel_e sel_a, sel_b, sel_d;
    flags_t flags;
    // execute to memory
    word_t mem_addr, mem_wdata;
    reg_idx_t mem_dest;
    logic mem_load, mem_store, mem_write, mem_valid;
    logic wb_we;

    exec_bus_if exec_bus ();
    stage_status_if status ();

    fetch_stage u_fetch (
        .clk, .rst, .stall, .branch_taken, .branch_target,
        .imem_we, .imem_addr, .imem_wdata,
        .if_valid, .if_instr, .if_pc_next
    );

    decode_stage u_decode (
        .clk, .rst, .if_valid, .if_instr, .if_pc_next,
        .sel_a, .sel_b, .sel_d, .stall,
        .branch_taken, .branch_target, .ra, .rb, .rd_sel, .uses_b, .uses_d,
        .a_data, .b_data, .d_data, .flags,
        .fwd(status.forward), .ex(exec_bus.decode)
    );

    // written from MEM/WB
    reg_file u_rf (
        .clk, .ra, .rb, .rd_sel, .we(wb_we), .wa(wb_reg), .wd(wb_data),
        .a_data, .b_data, .d_data
    );

    hazard_unit u_hazard (
        .ra, .rb, .rd_sel, .uses_b, .uses_d, .st(status.hazard),
        .sel_a, .sel_b, .sel_d, .stall
    );

    execute_stage u_execute (
        .clk, .rst, .ex(exec_bus.execute), .st(status.ex_side), .flags,
        .mem_addr, .mem_wdata, .mem_load, .mem_store, .mem_dest, .mem_write, .mem_valid
    );

    memory_stage u_memory (
        .clk, .rst, .mem_addr, .mem_wdata, .mem_load, .mem_store, .mem_dest,
        .mem_write, .mem_valid, .mst(status.mem_side), .wst(status.wb_side),
        .wb_valid, .wb_reg, .wb_data, .wb_we
    );

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // power-on reset, held for ten clocks
    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    // period 100
    always #50 clk = ~clk;

endmodule

//--- arm_pipeline_props.sv
module arm_pipeline_props (
    input logic              clk,
    input logic              rst,
    input logic              wb_valid,
    input arm_pkg::reg_idx_t wb_reg,
    input logic              stall
);

    // once reset has been seen for an edge, nothing retires
    a_no_retire_in_rst: assert property (
        @(posedge clk) (rst && $past(rst)) |-> !wb_valid
    ) else $error("wb_valid high while rst held");

    // a load-use stall lasts a single cycle
    a_stall_one_cycle: assert property (
        @(posedge clk) disable iff (rst) stall |=> !stall
    ) else $error("stall held for two cycles");

    // retiring register index must be known
    a_wb_reg_known: assert property (
        @(posedge clk) disable iff (rst) wb_valid |-> !$isunknown(wb_reg)
    ) else $error("wb_reg unknown on retirement");

endmodule

bind arm_pipeline arm_pipeline_props u_props (
    .clk(clk),
    .rst(rst),
    .wb_valid(wb_valid),
    .wb_reg(wb_reg),
    .stall(stall)
);

//--- tb_arm_pipeline.sv
module tb_arm_pipeline;
    import arm_pkg::*;

    logic clk, rst, rst_init, rst_req;
    logic imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    word_t imem_wdata;
    logic wb_valid;
    reg_idx_t wb_reg;
    word_t wb_data;

    // program table
    word_t prog_words [4][IMEM_WORDS];
    int prog_len [4];
    int prog_exp [4];
    // program per run and whether reset cuts it short
    int run_prog [6] = '{0, 1, 2, 3, 2, 1};
    bit run_abort [6] = '{0, 0, 0, 0, 1, 0};
    int cur_p, cur_n;
    // model output in retirement order
    logic [3:0] exp_reg [256];
    word_t exp_val [256];
    int exp_n;
    logic [15:0] lfsr = 16'd64;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 100000;

    assign rst = rst_init | rst_req;

    tb_clk_gen u_clk (.clk(clk), .rst(rst_init));

    arm_pipeline u_dut (
        .clk, .rst, .imem_we, .imem_addr, .imem_wdata,
        .wb_valid, .wb_reg, .wb_data
    );

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [7:0] rand_imm8();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++)
        begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // condition AL on everything except branches
    function automatic word_t dp_imm_word(input logic [3:0] op, input logic s,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [7:0] imm);
        return {4'b1110, 3'b001, op, s, rn, rd, 4'b0000, imm};
    endfunction

    function automatic word_t dp_reg_word(input logic [3:0] op, input logic s,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [3:0] rm);
        return {4'b1110, 3'b000, op, s, rn, rd, 8'h00, rm};
    endfunction

    function automatic word_t ldst_word(input logic l, input logic u, input logic [3:0] rn,
                                        input logic [3:0] rd, input logic [11:0] off);
        return {4'b1110, 3'b010, 1'b1, u, 1'b0, 1'b0, l, rn, rd, off};
    endfunction

    function automatic word_t branch_word(input logic [3:0] cond, input logic [23:0] off);
        return {cond, 3'b101, 1'b0, off};
    endfunction

    task automatic emit(input word_t w);
        prog_words[cur_p][cur_n] = w;
        cur_n++;
    endtask

    // rest of memory funnels into a self loop at the last word
    task automatic end_prog(input int expected);
        prog_len[cur_p] = cur_n;
        prog_exp[cur_p] = expected;
        for (int w = cur_n; w < IMEM_WORDS; w++)
            prog_words[cur_p][w] = branch_word(4'b1110, 24'(62 - w));
    endtask

    // ISA condition table over flags n z c v
    function automatic logic cond_holds(input logic [3:0] c, input logic [3:0] f);
        logic base;
        case (c[3:1])
            3'd0: base = f[2];
            3'd1: base = f[1];
            3'd2: base = f[3];
            3'd3: base = f[0];
            3'd4: base = f[1] & ~f[2];
            3'd5: base = ~(f[3] ^ f[0]);
            3'd6: base = ~f[2] & ~(f[3] ^ f[0]);
            default: return c[0] == 1'b0;
        endcase
        // odd codes are the inverse
        return c[0] ? ~base : base;
    endfunction

    // sequential reference run of program p
    task automatic model_run(input int p);
        word_t r [16];
        word_t m [64];
        logic [3:0] f;
        word_t w, a, b, res, addr;
        logic [32:0] wide;
        logic c, v;
        int idx, nxt, off, steps;
        f = '0;
        idx = 0;
        steps = 0;
        exp_n = 0;
        while (idx < prog_len[p] && steps < 200)
        begin
            w = prog_words[p][idx];
            nxt = idx + 1;
            steps++;
            if (w[27:25] == 3'b101)
            begin
                off = w[23] ? int'({8'hFF, w[23:0]}) : int'({8'h00, w[23:0]});
                if (cond_holds(w[31:28], f))
                    nxt = idx + 1 + off;
            end
            else if (w[27:25] == 3'b010)
            begin
                addr = w[23] ? r[w[19:16]] + {20'h0, w[11:0]} : r[w[19:16]] - {20'h0, w[11:0]};
                if (w[20])
                begin
                    r[w[15:12]] = m[int'(addr[7:2])];
                    exp_reg[exp_n] = w[15:12];
                    exp_val[exp_n] = r[w[15:12]];
                    exp_n++;
                end
                else
                    m[int'(addr[7:2])] = r[w[15:12]];
            end
            else
            begin
                a = r[w[19:16]];
                b = w[25] ? {24'h0, w[7:0]} : r[w[3:0]];
                c = f[1];
                v = f[0];
                case (w[24:21])
                    4'b0000: res = a & b;
                    4'b0001: res = a ^ b;
                    4'b1100: res = a | b;
                    4'b0100:
                    begin
                        wide = {1'b0, a} + {1'b0, b};
                        res = wide[31:0];
                        c = wide[32];
                        v = (a[31] == b[31]) && (res[31] != a[31]);
                    end
                    4'b0010:
                    begin
                        res = a - b;
                        // no borrow when a >= b
                        c = (a >= b);
                        v = (a[31] != b[31]) && (res[31] != a[31]);
                    end
                    default: res = b;
                endcase
                if (w[20])
                    f = {res[31], res == 32'h0, c, v};
                r[w[15:12]] = res;
                exp_reg[exp_n] = w[15:12];
                exp_val[exp_n] = res;
                exp_n++;
            end
            idx = nxt;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // load under reset, release, then collect retirements
    task automatic run_program(input int run, input int p, input bit abort);
        int got, idle, cyc, err0;
        err0 = errors;
        model_run(p);
        check_val("model retire count", exp_n, prog_exp[p]);
        @(negedge clk);
        rst_req = 1'b1;
        for (int w = 0; w < IMEM_WORDS; w++)
        begin
            imem_we = 1'b1;
            imem_addr = IMEM_AW'(w);
            imem_wdata = prog_words[p][w];
            @(negedge clk);
        end
        imem_we = 1'b0;
        while (rst_init)
            @(negedge clk);
        rst_req = 1'b0;
        got = 0;
        idle = 0;
        cyc = 0;
        while (abort ? (cyc < 8) : (idle < 12))
        begin
            @(negedge clk);
            cyc++;
            if (wb_valid)
            begin
                if (got < exp_n)
                begin
                    check_val("wb_reg", 32'(wb_reg), 32'(exp_reg[got]));
                    check_val("wb_data", wb_data, exp_val[got]);
                end
                else
                begin
                    errors++;
                    $display("extra retirement beyond the expected list at t=%0t", $time);
                end
                got++;
                idle = 0;
            end
            else if (got >= exp_n)
                idle++;
        end
        if (abort)
        begin
            // reset mid-program stops retirements
            rst_req = 1'b1;
            repeat (3)
            begin
                @(negedge clk);
                check_val("wb_valid", 32'(wb_valid), 32'h0);
            end
        end
        else
            check_val("retire count", got, exp_n);
        $display("run %0d program %0d: %0d retired, %0d errors", run, p, got, errors - err0);
    endtask

    // cycle limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        int total;
        rst_req = 1'b1;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;

        // independent dp ops
        cur_p = 0;
        cur_n = 0;
        for (int i = 1; i <= 4; i++)
            emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'(i), rand_imm8()));
        emit(dp_reg_word(op_add, 1'b0, 4'd1, 4'd5, 4'd2));
        emit(dp_imm_word(op_and, 1'b0, 4'd3, 4'd6, rand_imm8()));
        emit(dp_reg_word(op_eor, 1'b0, 4'd4, 4'd7, 4'd2));
        emit(dp_imm_word(op_orr, 1'b0, 4'd1, 4'd8, rand_imm8()));
        end_prog(8);

        // back-to-back dependencies on rn and rm
        cur_p = 1;
        cur_n = 0;
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd1, rand_imm8()));
        emit(dp_imm_word(op_add, 1'b0, 4'd1, 4'd2, rand_imm8()));
        emit(dp_reg_word(op_sub, 1'b0, 4'd2, 4'd3, 4'd1));
        emit(dp_reg_word(op_eor, 1'b0, 4'd1, 4'd4, 4'd3));
        emit(dp_reg_word(op_orr, 1'b0, 4'd3, 4'd5, 4'd4));
        emit(dp_reg_word(op_and, 1'b0, 4'd4, 4'd6, 4'd2));
        emit(dp_reg_word(op_add, 1'b0, 4'd6, 4'd7, 4'd6));
        end_prog(7);

        // store, load, load-use
        cur_p = 2;
        cur_n = 0;
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd1, 8'h20));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd2, rand_imm8()));
        emit(ldst_word(1'b0, 1'b1, 4'd1, 4'd2, 12'h004));
        emit(ldst_word(1'b1, 1'b1, 4'd1, 4'd3, 12'h004));
        emit(dp_imm_word(op_add, 1'b0, 4'd3, 4'd4, 8'h01));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd5, rand_imm8()));
        emit(ldst_word(1'b0, 1'b1, 4'd1, 4'd5, 12'h008));
        emit(ldst_word(1'b1, 1'b1, 4'd1, 4'd6, 12'h008));
        emit(dp_reg_word(op_add, 1'b0, 4'd1, 4'd7, 4'd6));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd9, 8'h30));
        // down offset lands on the first stored word
        emit(ldst_word(1'b1, 1'b0, 4'd9, 4'd8, 12'h00C));
        emit(dp_reg_word(op_eor, 1'b0, 4'd8, 4'd10, 4'd2));
        end_prog(10);

        // flags then branches with one filler between setter and branch
        cur_p = 3;
        cur_n = 0;
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd1, 8'd5));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd2, 8'd5));
        emit(dp_reg_word(op_sub, 1'b1, 4'd1, 4'd3, 4'd2));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd4, rand_imm8()));
        emit(branch_word(cond_eq, 24'd1));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd5, 8'hEE));
        emit(branch_word(cond_ne, 24'd1));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd6, rand_imm8()));
        emit(branch_word(cond_cc, 24'd1));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd7, rand_imm8()));
        emit(dp_imm_word(op_sub, 1'b1, 4'd2, 4'd8, 8'd9));
        // dependent add with carry out sets the flags the branches test
        emit(dp_imm_word(op_add, 1'b1, 4'd8, 4'd8, 8'h0F));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd10, rand_imm8()));
        emit(branch_word(cond_mi, 24'd1));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd11, rand_imm8()));
        emit(branch_word(cond_ge, 24'd1));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd12, 8'hEE));
        emit(branch_word(cond_lt, 24'd1));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd13, rand_imm8()));
        emit(branch_word(cond_hi, 24'd1));
        emit(dp_imm_word(op_mov, 1'b0, 4'd0, 4'd14, 8'hEE));
        end_prog(11);

        // each run pays a memory load plus drain time
        total = 0;
        foreach (run_prog[i])
            total += prog_exp[run_prog[i]];
        limit = total * 4 + 6 * (IMEM_WORDS + 40) + 100;

        foreach (run_prog[i])
            run_program(i, run_prog[i], run_abort[i]);

        $display("runs %0d, checks %0d, errors %0d", 6, checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- build.f
arm_pkg.sv
pipe_ifs.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
arm_pipeline.sv
tb_clk_gen.sv
arm_pipeline_props.sv
tb_arm_pipeline.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module tb_arm_pipeline -o sim_arm_pipeline > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_arm_pipeline > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1
